// File: l1_cache_stim.txt
// op addr byte_en wdata expected, all hex; op 1 read, 2 write
// expected column unused on writes; memory word starts as addr ^ a5a50000
1 00000008 0 00000000 a5a50008
1 0000000c 0 00000000 a5a5000c
1 00000008 0 00000000 a5a50008
2 0000000c 5 11223344 00000000
1 0000000c 0 00000000 a5220044
1 00000088 0 00000000 a5a50088
1 00000108 0 00000000 a5a50108
1 0000000c 0 00000000 a5220044
1 00000008 0 00000000 a5a50008
2 00000010 f deadbeef 00000000
1 00000010 0 00000000 deadbeef
1 00000014 0 00000000 a5a50014
2 00000204 c cafe0000 00000000
1 00000204 0 00000000 cafe0204
2 80000010 3 12345678 00000000
1 80000010 0 00000000 25a55678
1 80000014 0 00000000 25a50014
2 80000014 f 0badf00d 00000000
1 80000014 0 00000000 0badf00d
1 00000010 0 00000000 deadbeef
1 00000090 0 00000000 a5a50090
1 00000110 0 00000000 a5a50110
1 00000010 0 00000000 deadbeef

// File: l1_cache.f
l1_cache_pkg.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
l1_cache.sv
tb_clock_gen.sv
tb_mem_model.sv
l1_cache_assert.sv
tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

sources:
  - l1_cache_pkg.sv
  - cache_way.sv
  - way_select.sv
  - cache_ctrl.sv
  - l1_cache.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mem_model.sv
      - l1_cache_assert.sv
      - tb_l1_cache.sv

// File: tb_l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_l1_cache import l1_cache_pkg::*; ();

    localparam int    CACHE_SIZE      = 256;
    localparam int    BLOCK_SIZE      = 2;
    localparam int    ASSOC           = 2;
    localparam word_t NONCACHE_START  = 32'h8000_0000;
    localparam int    PERIOD          = 8;
    localparam int    RESET_CYCLES    = 8;
    localparam int    MAX_LINES       = 64;
    localparam int    FIELDS          = 5;     // op addr byte_en wdata expected
    localparam int    CYCLES_PER_LINE = 40;
    localparam word_t BLOCK_MASK      = ~word_t'(BLOCK_SIZE * 4 - 1);   // drops offset bits

    typedef enum logic [31:0] {
        OP_END   = 32'd0,     // unfilled entry ends the list
        OP_READ  = 32'd1,
        OP_WRITE = 32'd2
    } op_e;

    logic     CLK;
    logic     nRST;
    bus_req_t proc_req;
    bus_rsp_t proc_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;

    word_t stim [MAX_LINES*FIELDS];
    int    n_lines     = 0;
    int    n_checks    = 0;
    int    n_errors    = 0;
    int    cycle_cnt   = 0;
    int    cycle_limit = 1000;

    tb_clock_gen #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    tb_mem_model mem_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    l1_cache #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .ASSOC               (ASSOC),
        .NONCACHE_START_ADDR (NONCACHE_START)
    ) dut_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .proc_req (proc_req),
        .proc_rsp (proc_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    // one request held from a falling edge until busy is seen low
    task automatic run_access(input op_e op, input word_t addr, input byte_en_t be,
                              input word_t wdata, output word_t rdata, output int waits);
        @(negedge CLK);
        proc_req.ren     = (op == OP_READ);
        proc_req.wen     = (op == OP_WRITE);
        proc_req.addr    = addr;
        proc_req.wdata   = wdata;
        proc_req.byte_en = be;
        waits            = 0;
        @(posedge CLK);                  // pre-edge values are stable here
        while (proc_rsp.busy) begin
            waits++;                     // busy edges before completion
            @(posedge CLK);
        end
        rdata = proc_rsp.rdata;
        @(negedge CLK);
        proc_req = '0;
    endtask

    task automatic check_read(input word_t addr, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: read of %h returned %h, expected %h",
                     $time, addr, got, exp);
        end
    endtask

    // resident block must complete in the request cycle
    task automatic expect_hit(input word_t addr, input int waits);
        n_checks++;
        if (waits != 0) begin
            n_errors++;
            $display("error at %0t ns: access to %h waited %0d cycles, expected a hit",
                     $time, addr, waits);
        end
    endtask

    // run limit covers the whole stimulus at the per-line budget
    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, a request never completed", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        word_t got;
        op_e   op;
        int    base;
        int    waits;
        word_t prev_blk;
        logic  prev_valid;
        int    assert_fails;
        proc_req   = '0;
        prev_blk   = '0;
        prev_valid = 1'b0;
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("l1_cache_stim.txt", stim);
        while (n_lines < MAX_LINES && stim[n_lines*FIELDS] != OP_END) begin
            n_lines++;
        end
        cycle_limit = RESET_CYCLES + 2 + CYCLES_PER_LINE * n_lines;
        if (n_lines == 0) begin
            $display("no stimulus lines found in l1_cache_stim.txt");
            n_errors++;
        end

        wait (nRST === 1'b1);
        for (int i = 0; i < n_lines; i++) begin
            base = i * FIELDS;
            op   = op_e'(stim[base]);
            if (op != OP_READ && op != OP_WRITE) begin
                $display("stimulus line %0d holds an unknown operation %h", i, stim[base]);
                n_errors++;
            end else begin
                run_access(op, stim[base+1], byte_en_t'(stim[base+2]), stim[base+3],
                           got, waits);
                if (op == OP_READ) begin
                    check_read(stim[base+1], got, stim[base+4]);
                end
                // last cacheable block stays resident, pass-through leaves it alone
                if (stim[base+1] < NONCACHE_START) begin
                    if (prev_valid && (stim[base+1] & BLOCK_MASK) == prev_blk) begin
                        expect_hit(stim[base+1], waits);
                    end
                    prev_blk   = stim[base+1] & BLOCK_MASK;
                    prev_valid = 1'b1;
                end
            end
        end
        repeat (2) @(negedge CLK);

        assert_fails = dut_i.ctrl_i.assert_i.fail_cnt;
        $display("lines: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 n_lines, n_checks, n_errors, assert_fails);
        if (n_errors == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: l1_cache_assert.sv
`timescale 1ns/1ns
`default_nettype none

module l1_cache_assert import l1_cache_pkg::*; (
    input logic     CLK,
    input logic     nRST,
    input bus_req_t mem_req,
    input bus_rsp_t mem_rsp
);

    int   fail_cnt = 0;    // failed assertion count
    logic mem_access;

    assign mem_access = mem_req.ren | mem_req.wen;

    a_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            $error("memory read and write requested in the same cycle");
            fail_cnt++;
        end

    a_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        mem_access |-> (mem_req.addr[1:0] == 2'b00))
        else begin
            $error("memory address %h not word aligned", mem_req.addr);
            fail_cnt++;
        end

    // request held until memory drops busy
    a_hold_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_access && mem_rsp.busy) |=> $stable(mem_req))
        else begin
            $error("memory request changed while busy was high");
            fail_cnt++;
        end

endmodule

bind cache_ctrl l1_cache_assert assert_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model import l1_cache_pkg::*; #(
    parameter int    MEM_WORDS = 2048,            // low window plus window at 32'h8000_0000
    parameter word_t INIT_XOR  = 32'hA5A5_0000
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t mem_req,
    output bus_rsp_t mem_rsp
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            store   [MEM_WORDS];
    logic             written [MEM_WORDS];   // word differs from the initial pattern
    logic [1:0]       stall_left;            // busy cycles still owed this transfer
    logic [1:0]       stall_next;
    logic             active;
    logic [IDX_W-1:0] idx;
    word_t            cur_word;
    word_t            merged;
    integer           seed = 89;

    always_comb begin
        active   = mem_req.ren | mem_req.wen;
        idx      = {mem_req.addr[31], mem_req.addr[IDX_W:2]};   // top bit picks the window
        // untouched words read as their own full address xor pattern
        cur_word = written[idx] ? store[idx] : (mem_req.addr ^ INIT_XOR);
        merged   = cur_word;
        for (int b = 0; b < WORD_SIZE / 8; b++) begin
            if (mem_req.byte_en[b]) begin
                merged[8*b +: 8] = mem_req.wdata[8*b +: 8];
            end
        end
        mem_rsp.busy  = !active || (stall_left != 2'd0);
        mem_rsp.rdata = cur_word;
    end

    // transfer completes on the edge where busy is low
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stall_next <= 2'd0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                written[i] <= 1'b0;
            end
        end else if (active && stall_left == 2'd0) begin
            if (mem_req.wen) begin
                store[idx]   <= merged;
                written[idx] <= 1'b1;
            end
            stall_next <= 2'($random(seed));   // 0 to 3 stalls for the next one
        end else if (active) begin
            stall_next <= stall_left - 2'd1;
        end
    end

    // busy only moves on the falling edge
    always @(negedge CLK, negedge nRST) begin
        if (!nRST) begin
            stall_left <= 2'd0;
        end else begin
            stall_left <= stall_next;
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,    // ns
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

// File: l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

module l1_cache import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,            // bytes, power of 2
    parameter int    BLOCK_SIZE          = 2,               // words, power of 2, at least 2
    parameter int    ASSOC               = 1,               // 1 or 2
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000,   // this and above bypass the cache
    localparam int   N_SETS              = CACHE_SIZE / (BLOCK_SIZE * (WORD_SIZE / 8) * ASSOC),
    localparam int   SET_W               = $clog2(N_SETS),
    localparam int   BLK_W               = $clog2(BLOCK_SIZE),
    localparam int   TAG_W               = WORD_SIZE - SET_W - BLK_W - 2,
    localparam int   WAY_W               = (ASSOC > 1) ? $clog2(ASSOC) : 1
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);

    // controller to ways
    logic [SET_W-1:0]                  set_idx;
    logic [TAG_W-1:0]                  tag;
    logic [BLK_W-1:0]                  word_sel;
    logic [ASSOC-1:0]                  way_wen;
    word_t                             wr_data;
    byte_en_t                          wr_byte_en;
    logic                              set_valid;
    logic                              clr_dirty;

    // ways to way select
    logic [ASSOC-1:0]                  way_hit;
    logic [ASSOC-1:0]                  way_dirty;
    logic [ASSOC-1:0][TAG_W-1:0]       way_tag;
    word_t [ASSOC-1:0][BLOCK_SIZE-1:0] way_block;

    // way select to controller and back
    logic                              hit;
    logic [WAY_W-1:0]                  hit_way;
    word_t [BLOCK_SIZE-1:0]            hit_data;
    logic [WAY_W-1:0]                  victim_way;
    logic                              victim_dirty;
    logic [TAG_W-1:0]                  victim_tag;
    logic                              touch;
    logic [WAY_W-1:0]                  touch_way;

    cache_ctrl #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .ASSOC               (ASSOC),
        .NONCACHE_START_ADDR (NONCACHE_START_ADDR)
    ) ctrl_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_req     (proc_req),
        .proc_rsp     (proc_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .set_idx      (set_idx),
        .tag          (tag),
        .word_sel     (word_sel),
        .way_wen      (way_wen),
        .wr_data      (wr_data),
        .wr_byte_en   (wr_byte_en),
        .set_valid    (set_valid),
        .clr_dirty    (clr_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .touch        (touch),
        .touch_way    (touch_way)
    );

    // one storage way per degree of associativity
    for (genvar w = 0; w < ASSOC; w++) begin : g_way
        cache_way #(
            .CACHE_SIZE (CACHE_SIZE),
            .BLOCK_SIZE (BLOCK_SIZE),
            .ASSOC      (ASSOC)
        ) way_i (
            .CLK        (CLK),
            .nRST       (nRST),
            .set_idx    (set_idx),
            .tag        (tag),
            .word_sel   (word_sel),
            .wr_en      (way_wen[w]),
            .wr_data    (wr_data),
            .wr_byte_en (wr_byte_en),
            .set_valid  (set_valid),
            .clr_dirty  (clr_dirty),
            .hit        (way_hit[w]),
            .dirty      (way_dirty[w]),
            .way_tag    (way_tag[w]),
            .rd_block   (way_block[w])
        );
    end

    way_select #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE),
        .ASSOC      (ASSOC)
    ) sel_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .set_idx      (set_idx),
        .way_hit      (way_hit),
        .way_dirty    (way_dirty),
        .way_tag      (way_tag),
        .way_block    (way_block),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_data     (hit_data),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import l1_cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,
    parameter int    BLOCK_SIZE          = 2,
    parameter int    ASSOC               = 1,
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int   N_SETS              = CACHE_SIZE / (BLOCK_SIZE * (WORD_SIZE / 8) * ASSOC),
    localparam int   SET_W               = $clog2(N_SETS),
    localparam int   BLK_W               = $clog2(BLOCK_SIZE),
    localparam int   TAG_W               = WORD_SIZE - SET_W - BLK_W - 2,
    localparam int   WAY_W               = (ASSOC > 1) ? $clog2(ASSOC) : 1
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  bus_req_t               proc_req,
    output bus_rsp_t               proc_rsp,
    output bus_req_t               mem_req,
    input  bus_rsp_t               mem_rsp,
    // way control, same to every way except the enables
    output logic [SET_W-1:0]       set_idx,
    output logic [TAG_W-1:0]       tag,
    output logic [BLK_W-1:0]       word_sel,
    output logic [ASSOC-1:0]       way_wen,
    output word_t                  wr_data,
    output byte_en_t               wr_byte_en,
    output logic                   set_valid,
    output logic                   clr_dirty,
    // from way select
    input  logic                   hit,
    input  logic [WAY_W-1:0]       hit_way,
    input  word_t [BLOCK_SIZE-1:0] hit_data,
    input  logic [WAY_W-1:0]       victim_way,
    input  logic                   victim_dirty,
    input  logic [TAG_W-1:0]       victim_tag,
    output logic                   touch,
    output logic [WAY_W-1:0]       touch_way
);

    ctrl_state_e      state_q, state_d;
    logic [BLK_W-1:0] word_cnt_q;           // word within block being moved
    word_t            mem_addr_q, mem_addr_d;
    logic [BLK_W-1:0] addr_word;
    logic             access;
    logic             noncache;
    logic             last_word;
    logic             step;
    word_t            wb_base, fetch_base;

    // address split
    assign tag       = proc_req.addr[WORD_SIZE-1 -: TAG_W];
    assign set_idx   = proc_req.addr[2+BLK_W +: SET_W];
    assign addr_word = proc_req.addr[2 +: BLK_W];

    assign access    = proc_req.ren | proc_req.wen;
    assign noncache  = proc_req.addr >= NONCACHE_START_ADDR;   // goes straight to memory
    assign last_word = word_cnt_q == BLK_W'(BLOCK_SIZE - 1);
    assign step      = (state_q != IDLE) && !mem_rsp.busy;      // one block word done

    // block base addresses, old owner and new owner
    assign wb_base    = {victim_tag, set_idx, {BLK_W{1'b0}}, 2'b00};
    assign fetch_base = {tag, set_idx, {BLK_W{1'b0}}, 2'b00};

    // way port muxing, cpu side in idle, memory side during a fill
    assign word_sel   = (state_q == IDLE) ? addr_word : word_cnt_q;
    assign wr_data    = (state_q == IDLE) ? proc_req.wdata : mem_rsp.rdata;
    assign wr_byte_en = (state_q == IDLE) ? proc_req.byte_en : '1;
    assign clr_dirty  = state_q == FETCH;
    assign set_valid  = (state_q == FETCH) && last_word;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q    <= IDLE;
            word_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (step) begin
                word_cnt_q <= word_cnt_q + 1'b1;   // wraps to 0 after last word
            end
        end
    end

    always_ff @(posedge CLK) begin
        mem_addr_q <= mem_addr_d;
    end

    // memory address register, holds while memory is busy
    always_comb begin
        mem_addr_d = mem_addr_q;
        case (state_q)
            IDLE: begin
                mem_addr_d = victim_dirty ? wb_base : fetch_base;
            end
            WRITEBACK: begin
                if (step) begin
                    mem_addr_d = last_word ? fetch_base : mem_addr_q + 32'd4;
                end
            end
            FETCH: begin
                if (step) begin
                    mem_addr_d = mem_addr_q + 32'd4;
                end
            end
            default: mem_addr_d = mem_addr_q;
        endcase
    end

    // next state, bus outputs, way enables
    always_comb begin
        state_d        = state_q;
        proc_rsp.busy  = 1'b1;                   // busy unless something completes
        proc_rsp.rdata = hit_data[addr_word];
        mem_req        = '0;
        way_wen        = '0;
        touch          = 1'b0;
        touch_way      = hit_way;
        case (state_q)
            IDLE: begin
                if (access && noncache) begin
                    mem_req  = proc_req;          // forwarded as is, lanes included
                    proc_rsp = mem_rsp;           // done when memory drops busy
                end else if (access && hit) begin
                    proc_rsp.busy    = 1'b0;      // zero latency hit
                    touch            = 1'b1;
                    way_wen[hit_way] = proc_req.wen;
                end else if (access) begin
                    // miss, clean the victim first if needed
                    state_d = victim_dirty ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = mem_addr_q;
                mem_req.wdata   = hit_data[word_cnt_q];   // victim block, no hit here
                mem_req.byte_en = '1;
                if (step && last_word) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = mem_addr_q;
                mem_req.byte_en = '1;
                if (step) begin
                    way_wen[victim_way] = 1'b1;           // fill word into victim frame
                    if (last_word) begin
                        state_d = IDLE;                   // access hits next cycle
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: way_select.sv
`timescale 1ns/1ns
`default_nettype none

module way_select import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,
    parameter int  BLOCK_SIZE = 2,
    parameter int  ASSOC      = 1,
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * (WORD_SIZE / 8) * ASSOC),
    localparam int SET_W      = $clog2(N_SETS),
    localparam int BLK_W      = $clog2(BLOCK_SIZE),
    localparam int TAG_W      = WORD_SIZE - SET_W - BLK_W - 2,
    localparam int WAY_W      = (ASSOC > 1) ? $clog2(ASSOC) : 1
) (
    input  logic                               CLK,
    input  logic                               nRST,
    input  logic [SET_W-1:0]                   set_idx,
    input  logic [ASSOC-1:0]                   way_hit,
    input  logic [ASSOC-1:0]                   way_dirty,
    input  logic [ASSOC-1:0][TAG_W-1:0]        way_tag,
    input  word_t [ASSOC-1:0][BLOCK_SIZE-1:0]  way_block,
    input  logic                               touch,        // way used this cycle
    input  logic [WAY_W-1:0]                   touch_way,
    output logic                               hit,
    output logic [WAY_W-1:0]                   hit_way,
    output word_t [BLOCK_SIZE-1:0]             hit_data,
    output logic [WAY_W-1:0]                   victim_way,
    output logic                               victim_dirty,
    output logic [TAG_W-1:0]                   victim_tag
);

    logic [N_SETS-1:0] last_used;    // one lru bit per set
    logic              lru_victim;   // way not used last in this set
    logic [WAY_W-1:0]  data_way;

    // at most one way matches, loop just encodes it
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (way_hit[i]) begin
                hit     = 1'b1;
                hit_way = WAY_W'(i);
            end
        end
    end

    assign lru_victim = ~last_used[set_idx];
    assign victim_way = (ASSOC == 2) ? WAY_W'(lru_victim) : '0;   // direct mapped, way 0

    // on a miss the victim block shows up here, feeds write-back
    assign data_way     = hit ? hit_way : victim_way;
    assign hit_data     = way_block[data_way];
    assign victim_dirty = way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[set_idx] <= touch_way[0];
        end
    end

endmodule

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/1ns
`default_nettype none

module cache_way import l1_cache_pkg::*; #(
    parameter int  CACHE_SIZE = 1024,   // bytes, power of 2
    parameter int  BLOCK_SIZE = 2,      // words per block, power of 2, at least 2
    parameter int  ASSOC      = 1,      // 1 or 2
    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * (WORD_SIZE / 8) * ASSOC),
    localparam int SET_W      = $clog2(N_SETS),
    localparam int BLK_W      = $clog2(BLOCK_SIZE),
    localparam int TAG_W      = WORD_SIZE - SET_W - BLK_W - 2
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [SET_W-1:0]       set_idx,
    input  logic [TAG_W-1:0]       tag,
    input  logic [BLK_W-1:0]       word_sel,
    input  logic                   wr_en,        // this way is written this cycle
    input  word_t                  wr_data,
    input  byte_en_t               wr_byte_en,
    input  logic                   set_valid,    // last fill word, store tag too
    input  logic                   clr_dirty,    // fill write, leaves frame clean
    output logic                   hit,
    output logic                   dirty,
    output logic [TAG_W-1:0]       way_tag,
    output word_t [BLOCK_SIZE-1:0] rd_block
);

    logic [N_SETS-1:0]      valid_q;
    logic [N_SETS-1:0]      dirty_q;
    logic [TAG_W-1:0]       tag_q  [N_SETS];
    word_t [BLOCK_SIZE-1:0] data_q [N_SETS];
    word_t                  merged;            // addressed word after lane merge

    // enabled lanes take new bytes, the rest keep old ones
    always_comb begin
        merged = data_q[set_idx][word_sel];
        for (int b = 0; b < WORD_SIZE / 8; b++) begin
            if (wr_byte_en[b]) begin
                merged[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
    end

    // frame status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            dirty_q[set_idx] <= ~clr_dirty;    // cpu write dirties, fill cleans
            if (set_valid) begin
                valid_q[set_idx] <= 1'b1;
            end
        end
    end

    // tag and block storage
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            data_q[set_idx][word_sel] <= merged;
            if (set_valid) begin
                tag_q[set_idx] <= tag;         // frame now belongs to new tag
            end
        end
    end

    // combinational read of addressed set
    assign hit      = valid_q[set_idx] && (tag_q[set_idx] == tag);
    assign dirty    = dirty_q[set_idx];    // only ever set on a valid frame
    assign way_tag  = tag_q[set_idx];
    assign rd_block = data_q[set_idx];

endmodule

`default_nettype wire

// File: l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

    // machine word, also the address width
    localparam int WORD_SIZE = 32;

    typedef logic [WORD_SIZE-1:0]     word_t;
    typedef logic [WORD_SIZE/8-1:0]   byte_en_t;   // one enable per byte lane

    // request side of either bus, held until busy is seen low
    typedef struct packed {
        logic     ren;
        logic     wen;       // never high with ren
        word_t    addr;      // byte address, word aligned
        word_t    wdata;
        byte_en_t byte_en;   // lanes written, others untouched
    } bus_req_t;

    // response side of either bus
    typedef struct packed {
        logic  busy;         // low cycle completes the transfer
        word_t rdata;        // valid in the completing cycle
    } bus_rsp_t;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE,                // serve hits and pass-through, detect misses
        WRITEBACK,           // push dirty victim words out
        FETCH                // pull the new block in
    } ctrl_state_e;

endpackage

`default_nettype wire
